/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_usb_endpoint
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) usb_ep_defs.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+.
usb_ep_pkg.sv
usb_trans_fifo.sv
usb_endpoint_in.sv
usb_endpoint_out.sv
usb_endpoint.sv
usb_endpoint_chk.sv
tb_usb_endpoint.sv

/* tb_usb_endpoint.sv */
`timescale 1ns/1ps
`include "usb_ep_defs.svh"

module tb_usb_endpoint
    import usb_ep_pkg::*;
();

    localparam int NUM_PKTS = 24;
    localparam int MAX_LEN  = 70;
    localparam int TIMEOUT  = NUM_PKTS * (MAX_LEN * 4 + 20) * 20; // In ns.

    logic                         clk12_i;
    logic                         rst_i;
    logic                         got_trans_start_packet_i;
    logic                         is_host_in_i;
    token_e                       trans_start_token_id_i;
    logic [`USB_DEV_CONF_WID-1:0] device_conf_i;
    logic                         reset_data_toggle_i;
    logic                         ep_in_fill_trans_done_i;
    logic                         ep_in_fill_trans_success_i;
    logic                         ep_in_data_valid_i;
    logic [7:0]                   ep_in_data_i;
    logic                         ep_in_full_o;
    logic                         ep_in_pop_trans_done_i;
    logic                         ep_in_pop_trans_success_i;
    logic                         ep_in_pop_data_i;
    logic                         ep_in_data_available_o;
    logic [7:0]                   ep_in_data_o;
    logic                         ep_out_fill_trans_done_i;
    logic                         ep_out_fill_trans_success_i;
    logic                         ep_out_data_valid_i;
    logic [7:0]                   ep_out_data_i;
    logic                         ep_out_full_o;
    logic                         ep_out_pop_trans_done_i;
    logic                         ep_out_pop_trans_success_i;
    logic                         ep_out_pop_data_i;
    logic                         ep_out_data_available_o;
    logic                         ep_out_is_last_packet_byte_o;
    logic [7:0]                   ep_out_data_o;
    ep_resp_t                     resp_o;

    ep_resp_t    exp_next; // Response due after the coming edge.
    ep_resp_t    exp_cur;
    logic [15:0] lfsr_q;
    logic [7:0]  pkt_q[$];
    logic [7:0]  m_in_pkt[$];  // Committed IN packet.
    logic [7:0]  m_out_pkt[$]; // Committed OUT packet.
    bit          m_in_tog;
    bit          m_conf;
    bit          m_nak_pend;

    usb_endpoint usb_endpoint_i (.*);

    initial begin
        clk12_i = 1'b0;
        forever #10 clk12_i = ~clk12_i;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before the tests completed.");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic get_rand(input int nbits, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v      = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // Expected response from the endpoint rules.
    function automatic ep_resp_t ref_resp(input bit start, input bit host_in, input token_e tok,
                                          input bit fill_end, input bit commit);
        ep_resp_t r;
        r = '0;
        if (!m_conf) begin
            return r;
        end
        if (start && host_in && (tok == TOKEN_IN)) begin
            r.valid = 1'b1;
            if (m_in_pkt.size() > 0) begin
                r.is_handshake = 1'b0;
                r.pid.data     = m_in_tog ? `USB_PID_DATA1 : `USB_PID_DATA0;
            end else begin
                r.is_handshake  = 1'b1;
                r.pid.handshake = `USB_PID_NAK;
            end
        end else if (start && !host_in && (tok == TOKEN_OUT || tok == TOKEN_SETUP) &&
                     m_out_pkt.size() > 0) begin
            r.valid         = 1'b1;
            r.is_handshake  = 1'b1;
            r.pid.handshake = `USB_PID_NAK;
        end else if (fill_end) begin
            r.valid         = 1'b1;
            r.is_handshake  = 1'b1;
            r.pid.handshake = commit ? `USB_PID_ACK : `USB_PID_NAK;
        end
        return r;
    endfunction

    // Compares the response registered in the previous cycle.
    always @(posedge clk12_i) begin
        if (!rst_i) begin
            check_val("resp_o.valid", resp_o.valid, exp_cur.valid);
            if (exp_cur.valid) begin
                check_val("resp_o", resp_o, exp_cur);
            end
        end
        exp_cur = exp_next;
    end

    task automatic clear_strobes();
        got_trans_start_packet_i    = 1'b0;
        reset_data_toggle_i         = 1'b0;
        ep_in_fill_trans_done_i     = 1'b0;
        ep_in_data_valid_i          = 1'b0;
        ep_in_pop_trans_done_i      = 1'b0;
        ep_in_pop_data_i            = 1'b0;
        ep_out_fill_trans_done_i    = 1'b0;
        ep_out_data_valid_i         = 1'b0;
        ep_out_pop_trans_done_i     = 1'b0;
        ep_out_pop_data_i           = 1'b0;
        exp_next                    = '0;
    endtask

    task automatic next_cycle();
        @(negedge clk12_i);
        clear_strobes();
    endtask

    task automatic make_packet(input int len);
        logic [15:0] v;
        pkt_q.delete();
        for (int i = 0; i < len; i++) begin
            get_rand(8, v);
            pkt_q.push_back(v[7:0]);
        end
    endtask

    task automatic send_token(input bit host_in, input token_e tok);
        next_cycle();
        is_host_in_i             = host_in;
        trans_start_token_id_i   = tok;
        got_trans_start_packet_i = 1'b1;
        exp_next = ref_resp(1'b1, host_in, tok, 1'b0, 1'b0);
        if (!host_in && (tok == TOKEN_OUT || tok == TOKEN_SETUP) && m_out_pkt.size() > 0) begin
            m_nak_pend = 1'b1;
        end
        if (tok == TOKEN_SETUP) begin
            m_in_tog = 1'b0;
        end
        next_cycle(); // Mux stays on this half while the response is out.
        next_cycle();
    endtask

    task automatic fill_out(input int len, input bit success);
        bit saw_full;
        bit fill_ok;
        bit commit;
        saw_full = 1'b0;
        fill_ok  = m_conf && !m_nak_pend;
        make_packet(len);
        next_cycle();
        is_host_in_i = 1'b0;
        foreach (pkt_q[i]) begin
            next_cycle();
            saw_full            = saw_full | ep_out_full_o;
            ep_out_data_valid_i = 1'b1;
            ep_out_data_i       = pkt_q[i];
        end
        next_cycle();
        check_val("ep_out_full_o seen", saw_full, fill_ok && (len > 64));
        ep_out_fill_trans_done_i    = 1'b1;
        ep_out_fill_trans_success_i = success;
        commit   = fill_ok && success && (len <= 64);
        exp_next = ref_resp(1'b0, 1'b0, TOKEN_OUT, !m_nak_pend, commit);
        if (commit) begin
            m_out_pkt = pkt_q;
        end
        m_nak_pend = 1'b0;
        next_cycle();
        next_cycle();
        check_val("ep_out_data_available_o", ep_out_data_available_o, m_out_pkt.size() > 0);
    endtask

    task automatic fill_in(input int len);
        make_packet(len);
        foreach (pkt_q[i]) begin
            next_cycle();
            ep_in_data_valid_i = 1'b1;
            ep_in_data_i       = pkt_q[i];
        end
        next_cycle();
        check_val("ep_in_full_o", ep_in_full_o, m_conf && (m_in_pkt.size() + len >= 64));
        ep_in_fill_trans_done_i    = 1'b1;
        ep_in_fill_trans_success_i = 1'b1;
        if (m_conf) begin
            m_in_pkt = pkt_q;
        end
        next_cycle();
    endtask

    task automatic pop_out(input bit success);
        int n;
        n = m_out_pkt.size();
        for (int i = 0; i < n; i++) begin
            next_cycle();
            check_val("ep_out_data_available_o", ep_out_data_available_o, 1);
            ep_out_pop_data_i = 1'b1;
            next_cycle();
            check_val("ep_out_data_o", ep_out_data_o, m_out_pkt[i]);
            check_val("ep_out_is_last_packet_byte_o", ep_out_is_last_packet_byte_o, i == n - 1);
        end
        next_cycle();
        ep_out_pop_trans_done_i    = 1'b1;
        ep_out_pop_trans_success_i = success;
        if (success) begin
            m_out_pkt.delete();
        end
        next_cycle();
        check_val("ep_out_data_available_o", ep_out_data_available_o, m_out_pkt.size() > 0);
    endtask

    task automatic pop_in(input bit success);
        for (int i = 0; i < m_in_pkt.size(); i++) begin
            next_cycle();
            check_val("ep_in_data_available_o", ep_in_data_available_o, 1);
            ep_in_pop_data_i = 1'b1;
            next_cycle();
            check_val("ep_in_data_o", ep_in_data_o, m_in_pkt[i]);
        end
        next_cycle();
        ep_in_pop_trans_done_i    = 1'b1;
        ep_in_pop_trans_success_i = success;
        if (success) begin
            m_in_pkt.delete();
            m_in_tog = !m_in_tog;
        end
        next_cycle();
        check_val("ep_in_data_available_o", ep_in_data_available_o, m_in_pkt.size() > 0);
        check_val("ep_in_full_o", ep_in_full_o, m_in_pkt.size() >= 64);
    endtask

    task automatic rand_len(output int len);
        logic [15:0] v;
        get_rand(6, v);
        len = int'(v[5:0]) + 1;
    endtask

    initial begin
        int len;
        lfsr_q = 16'd73;
        exp_next = '0;
        exp_cur  = '0;
        m_in_tog = 1'b0;
        m_conf   = 1'b1;
        m_nak_pend = 1'b0;
        rst_i = 1'b1;
        is_host_in_i = 1'b0;
        trans_start_token_id_i = TOKEN_OUT;
        device_conf_i = 8'd1;
        ep_in_data_i = '0;
        ep_out_data_i = '0;
        ep_in_fill_trans_success_i = 1'b0;
        ep_in_pop_trans_success_i = 1'b0;
        ep_out_fill_trans_success_i = 1'b0;
        ep_out_pop_trans_success_i = 1'b0;
        clear_strobes();
        repeat (2) @(negedge clk12_i);
        rst_i = 1'b0;

        // OUT packets commit, ACK and pop back unchanged.
        repeat (4) begin
            rand_len(len);
            fill_out(len, 1'b1);
            pop_out(1'b1);
        end

        // IN retry keeps the PID, commit advances it.
        rand_len(len);
        fill_in(len);
        send_token(1'b1, TOKEN_IN);
        pop_in(1'b0);
        send_token(1'b1, TOKEN_IN);
        pop_in(1'b1);
        rand_len(len);
        fill_in(len);
        send_token(1'b1, TOKEN_IN);
        pop_in(1'b1);

        // NAK cases.
        send_token(1'b1, TOKEN_IN);
        rand_len(len);
        fill_out(len, 1'b1);
        send_token(1'b0, TOKEN_OUT);
        rand_len(len);
        fill_out(len, 1'b1);
        pop_out(1'b1);

        // Overflow and failed commit.
        fill_out(MAX_LEN, 1'b1);
        rand_len(len);
        fill_out(len, 1'b0);

        // Toggle reset by strobe and by SETUP.
        rand_len(len);
        fill_in(len);
        send_token(1'b1, TOKEN_IN);
        pop_in(1'b1);
        next_cycle();
        reset_data_toggle_i = 1'b1;
        m_in_tog = 1'b0;
        rand_len(len);
        fill_in(len);
        send_token(1'b1, TOKEN_IN);
        pop_in(1'b1);
        send_token(1'b0, TOKEN_SETUP);
        fill_in(64); // Fills the IN FIFO to the brim.
        send_token(1'b1, TOKEN_IN);
        pop_in(1'b1);

        // Unconfigured device gives no responses.
        next_cycle();
        device_conf_i = '0;
        m_conf = 1'b0;
        send_token(1'b1, TOKEN_IN);
        rand_len(len);
        fill_out(len, 1'b1);
        send_token(1'b1, TOKEN_IN);

        next_cycle();
        next_cycle();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* usb_endpoint.sv */
`timescale 1ns/1ps
`include "usb_ep_defs.svh"

module usb_endpoint
    import usb_ep_pkg::*;
(
    input  logic                         clk12_i,
    input  logic                         rst_i,

    input  logic                         got_trans_start_packet_i,
    input  logic                         is_host_in_i,
    input  token_e                       trans_start_token_id_i,
    input  logic [`USB_DEV_CONF_WID-1:0] device_conf_i,
    input  logic                         reset_data_toggle_i,

    input  logic                         ep_in_fill_trans_done_i,
    input  logic                         ep_in_fill_trans_success_i,
    input  logic                         ep_in_data_valid_i,
    input  logic [7:0]                   ep_in_data_i,
    output logic                         ep_in_full_o,

    input  logic                         ep_in_pop_trans_done_i,
    input  logic                         ep_in_pop_trans_success_i,
    input  logic                         ep_in_pop_data_i,
    output logic                         ep_in_data_available_o,
    output logic [7:0]                   ep_in_data_o, // Lags the pop by one cycle.

    input  logic                         ep_out_fill_trans_done_i,
    input  logic                         ep_out_fill_trans_success_i,
    input  logic                         ep_out_data_valid_i,
    input  logic [7:0]                   ep_out_data_i,
    output logic                         ep_out_full_o,

    input  logic                         ep_out_pop_trans_done_i,
    input  logic                         ep_out_pop_trans_success_i,
    input  logic                         ep_out_pop_data_i,
    output logic                         ep_out_data_available_o,
    output logic                         ep_out_is_last_packet_byte_o,
    output logic [7:0]                   ep_out_data_o,

    output ep_resp_t                     resp_o
);

    logic     toggle_clear;
    ep_resp_t resp_in;
    ep_resp_t resp_out;

    // SETUP restarts both directions at DATA0, whichever half it reaches.
    assign toggle_clear = reset_data_toggle_i ||
                          (got_trans_start_packet_i && (trans_start_token_id_i == TOKEN_SETUP));

    usb_endpoint_in usb_endpoint_in_i (
        .trans_start_i  (got_trans_start_packet_i && is_host_in_i),
        .token_i        (trans_start_token_id_i),
        .reset_toggle_i (toggle_clear),
        .resp_o         (resp_in),
        .*
    );

    usb_endpoint_out usb_endpoint_out_i (
        .trans_start_i  (got_trans_start_packet_i && !is_host_in_i),
        .token_i        (trans_start_token_id_i),
        .reset_toggle_i (toggle_clear),
        .resp_o         (resp_out),
        .*
    );

    assign resp_o = is_host_in_i ? resp_in : resp_out;

endmodule

/* usb_endpoint_chk.sv */
`timescale 1ns/1ps
`include "usb_ep_defs.svh"

module usb_endpoint_chk
    import usb_ep_pkg::*;
(
    input logic                         clk12_i,
    input logic                         rst_i,
    input logic [`USB_DEV_CONF_WID-1:0] device_conf_i,
    input ep_resp_t                     resp_o,
    input logic                         ep_in_full_o,
    input logic                         ep_in_data_available_o,
    input logic                         ep_out_full_o,
    input logic                         ep_out_data_available_o,
    input logic                         ep_out_data_valid_i,
    input logic                         ep_out_fill_trans_done_i,
    input logic                         ep_out_fill_trans_success_i,
    input logic                         ep_out_pop_trans_done_i,
    input logic                         ep_out_pop_trans_success_i
);

    // The response is a single cycle strobe.
    resp_pulse: assert property (@(posedge clk12_i) disable iff (rst_i)
        resp_o.valid |=> !resp_o.valid)
        else $error("response valid held for more than one cycle");

    // An unconfigured device stays silent.
    unconf_silent: assert property (@(posedge clk12_i) disable iff (rst_i)
        (device_conf_i == '0) |=> !resp_o.valid)
        else $error("response while unconfigured");

    reset_flags: assert property (@(posedge clk12_i)
        rst_i |=> !(ep_in_full_o || ep_in_data_available_o ||
                    ep_out_full_o || ep_out_data_available_o))
        else $error("flags set after reset");

    // Data only shows up through a commit or a read rewind.
    avail_rise: assert property (@(posedge clk12_i) disable iff (rst_i)
        $rose(ep_out_data_available_o) |->
            $past(ep_out_fill_trans_done_i && ep_out_fill_trans_success_i) ||
            $past(ep_out_pop_trans_done_i && !ep_out_pop_trans_success_i))
        else $error("data available without a commit");

    full_rise: assert property (@(posedge clk12_i) disable iff (rst_i)
        $rose(ep_out_full_o) |-> $past(ep_out_data_valid_i))
        else $error("full without a write");

endmodule

bind usb_endpoint usb_endpoint_chk usb_endpoint_chk_i (.*);

/* usb_endpoint_in.sv */
`timescale 1ns/1ps
`include "usb_ep_defs.svh"

module usb_endpoint_in
    import usb_ep_pkg::*;
(
    input  logic                         clk12_i,
    input  logic                         rst_i,

    input  logic                         trans_start_i,
    input  token_e                       token_i,
    input  logic [`USB_DEV_CONF_WID-1:0] device_conf_i,
    input  logic                         reset_toggle_i,

    input  logic                         ep_in_fill_trans_done_i,
    input  logic                         ep_in_fill_trans_success_i,
    input  logic                         ep_in_data_valid_i,
    input  logic [7:0]                   ep_in_data_i,
    output logic                         ep_in_full_o,

    input  logic                         ep_in_pop_trans_done_i,
    input  logic                         ep_in_pop_trans_success_i,
    input  logic                         ep_in_pop_data_i,
    output logic                         ep_in_data_available_o,
    output logic [7:0]                   ep_in_data_o,

    output ep_resp_t                     resp_o
);

    logic     configured;
    logic     in_start;
    logic     data_toggle_q; // Low for DATA0.
    ep_resp_t resp_q;

    assign configured = |device_conf_i;
    assign in_start   = trans_start_i && (token_i == TOKEN_IN);

    // Device fills, protocol engine pops.
    usb_trans_fifo #(
        .ADDR_WID(`USB_EP_IN_ADDR_WID)
    ) usb_trans_fifo_i (
        .clk12_i              (clk12_i),
        .rst_i                (rst_i),
        .fill_trans_done_i    (ep_in_fill_trans_done_i),
        .fill_trans_success_i (ep_in_fill_trans_success_i && configured),
        .fill_data_valid_i    (ep_in_data_valid_i && configured),
        .fill_data_i          (ep_in_data_i),
        .full_o               (ep_in_full_o),
        .pop_trans_done_i     (ep_in_pop_trans_done_i),
        .pop_trans_success_i  (ep_in_pop_trans_success_i),
        .pop_data_i           (ep_in_pop_data_i),
        .data_available_o     (ep_in_data_available_o),
        .is_last_byte_o       (),
        .data_o               (ep_in_data_o),
        .overflow_o           ()
    );

    // A rewound packet keeps its PID, only an acknowledged one advances it.
    always_ff @(posedge clk12_i) begin
        if (rst_i || reset_toggle_i) begin
            data_toggle_q <= 1'b0;
        end else if (ep_in_pop_trans_done_i && ep_in_pop_trans_success_i) begin
            data_toggle_q <= ~data_toggle_q;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            resp_q <= '0;
        end else begin
            resp_q.valid <= in_start && configured;
            if (in_start) begin
                if (ep_in_data_available_o) begin
                    resp_q.is_handshake <= 1'b0;
                    resp_q.pid.data     <= data_toggle_q ? `USB_PID_DATA1 : `USB_PID_DATA0;
                end else begin
                    resp_q.is_handshake  <= 1'b1;
                    resp_q.pid.handshake <= `USB_PID_NAK; // Nothing committed yet.
                end
            end
        end
    end

    assign resp_o = resp_q;

endmodule

/* usb_endpoint_out.sv */
`timescale 1ns/1ps
`include "usb_ep_defs.svh"

module usb_endpoint_out
    import usb_ep_pkg::*;
(
    input  logic                         clk12_i,
    input  logic                         rst_i,

    input  logic                         trans_start_i,
    input  token_e                       token_i,
    input  logic [`USB_DEV_CONF_WID-1:0] device_conf_i,
    input  logic                         reset_toggle_i,

    input  logic                         ep_out_fill_trans_done_i,
    input  logic                         ep_out_fill_trans_success_i,
    input  logic                         ep_out_data_valid_i,
    input  logic [7:0]                   ep_out_data_i,
    output logic                         ep_out_full_o,

    input  logic                         ep_out_pop_trans_done_i,
    input  logic                         ep_out_pop_trans_success_i,
    input  logic                         ep_out_pop_data_i,
    output logic                         ep_out_data_available_o,
    output logic                         ep_out_is_last_packet_byte_o,
    output logic [7:0]                   ep_out_data_o,

    output ep_resp_t                     resp_o
);

    logic     configured;
    logic     out_start;
    logic     busy_start;
    logic     nak_pending_q;
    logic     fill_ok;
    logic     fifo_overflow;
    logic     commit_ok;
    ep_resp_t resp_q;

    assign configured = |device_conf_i;
    assign out_start  = trans_start_i && ((token_i == TOKEN_OUT) || (token_i == TOKEN_SETUP));
    assign busy_start = out_start && ep_out_data_available_o; // Previous packet still unread.
    assign fill_ok    = configured && !nak_pending_q;
    assign commit_ok  = ep_out_fill_trans_done_i && ep_out_fill_trans_success_i &&
                        fill_ok && !fifo_overflow;

    // Protocol engine fills, device pops.
    usb_trans_fifo #(
        .ADDR_WID(`USB_EP_OUT_ADDR_WID)
    ) usb_trans_fifo_i (
        .clk12_i              (clk12_i),
        .rst_i                (rst_i),
        .fill_trans_done_i    (ep_out_fill_trans_done_i),
        .fill_trans_success_i (ep_out_fill_trans_success_i && fill_ok),
        .fill_data_valid_i    (ep_out_data_valid_i && fill_ok),
        .fill_data_i          (ep_out_data_i),
        .full_o               (ep_out_full_o),
        .pop_trans_done_i     (ep_out_pop_trans_done_i),
        .pop_trans_success_i  (ep_out_pop_trans_success_i),
        .pop_data_i           (ep_out_pop_data_i),
        .data_available_o     (ep_out_data_available_o),
        .is_last_byte_o       (ep_out_is_last_packet_byte_o),
        .data_o               (ep_out_data_o),
        .overflow_o           (fifo_overflow)
    );

    // The NAK went out at the start, so the rest of that fill is dropped.
    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            nak_pending_q <= 1'b0;
        end else if (busy_start) begin
            nak_pending_q <= 1'b1;
        end else if (ep_out_fill_trans_done_i) begin
            nak_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            resp_q <= '0;
        end else begin
            resp_q.valid <= configured &&
                            (busy_start || (ep_out_fill_trans_done_i && !nak_pending_q));
            if (busy_start) begin
                resp_q.is_handshake  <= 1'b1;
                resp_q.pid.handshake <= `USB_PID_NAK;
            end else if (ep_out_fill_trans_done_i) begin
                resp_q.is_handshake  <= 1'b1;
                resp_q.pid.handshake <= commit_ok ? `USB_PID_ACK : `USB_PID_NAK;
            end
        end
    end

    assign resp_o = resp_q;

endmodule

/* usb_ep_defs.svh */
`ifndef USB_EP_DEFS_SVH
`define USB_EP_DEFS_SVH

// FIFO depth as log2 of the byte count, one 64 byte bulk packet each.
`define USB_EP_IN_ADDR_WID  6
`define USB_EP_OUT_ADDR_WID 6

// Device configuration value, zero means unconfigured.
`define USB_DEV_CONF_WID 8

// Handshake PIDs in the two-bit short form.
`define USB_PID_ACK   2'd0
`define USB_PID_NAK   2'd2
`define USB_PID_STALL 2'd3

// Data PIDs in the two-bit short form.
`define USB_PID_DATA0 2'd0
`define USB_PID_DATA1 2'd2

`endif

/* usb_ep_pkg.sv */
package usb_ep_pkg;

    // Token PID short form, taken from PID bits [3:2].
    typedef enum logic [1:0] {
        TOKEN_OUT   = 2'b00,
        TOKEN_SOF   = 2'b01,
        TOKEN_IN    = 2'b10,
        TOKEN_SETUP = 2'b11
    } token_e;

    // The same two bits carry a handshake or a data PID.
    typedef union packed {
        logic [1:0] handshake; // ACK, NAK or STALL.
        logic [1:0] data;      // DATA0 or DATA1.
    } pid_u;

    // Response handed to the protocol engine.
    typedef struct packed {
        logic valid;        // One cycle strobe.
        logic is_handshake; // Selects how pid is decoded.
        pid_u pid;
    } ep_resp_t;

endpackage

/* usb_trans_fifo.sv */
`timescale 1ns/1ps

module usb_trans_fifo #(
    parameter int ADDR_WID = 6
) (
    input  logic       clk12_i,
    input  logic       rst_i,

    input  logic       fill_trans_done_i,
    input  logic       fill_trans_success_i,
    input  logic       fill_data_valid_i,
    input  logic [7:0] fill_data_i,
    output logic       full_o,

    input  logic       pop_trans_done_i,
    input  logic       pop_trans_success_i,
    input  logic       pop_data_i,
    output logic       data_available_o,
    output logic       is_last_byte_o,
    output logic [7:0] data_o,
    output logic       overflow_o
);

    localparam int DEPTH = 1 << ADDR_WID;

    // Bit 8 marks the last byte of a committed packet.
    logic [8:0] mem [DEPTH];

    logic [ADDR_WID:0] wr_ptr_q;     // Working write pointer.
    logic [ADDR_WID:0] wr_commit_q;  // Last committed write pointer.
    logic [ADDR_WID:0] rd_ptr_q;     // Working read pointer.
    logic [ADDR_WID:0] rd_release_q; // Last released read pointer.
    logic              overflow_q;

    logic              fill_wr;
    logic              pop_rd;
    logic              commit_ok;
    logic [ADDR_WID:0] wr_ptr_next;
    logic [ADDR_WID:0] rd_ptr_next;
    logic [ADDR_WID:0] last_ptr;

    // Space is only freed once the reader releases it.
    assign full_o = (wr_ptr_q[ADDR_WID] != rd_release_q[ADDR_WID]) &&
                    (wr_ptr_q[ADDR_WID-1:0] == rd_release_q[ADDR_WID-1:0]);
    assign data_available_o = (rd_ptr_q != wr_commit_q); // Committed and unread.

    assign fill_wr     = fill_data_valid_i && !full_o;
    assign overflow_o  = overflow_q || (fill_data_valid_i && full_o);
    assign commit_ok   = fill_trans_done_i && fill_trans_success_i && !overflow_o;
    assign wr_ptr_next = wr_ptr_q + {{ADDR_WID{1'b0}}, fill_wr};
    assign last_ptr    = wr_ptr_next - {{ADDR_WID{1'b0}}, 1'b1};

    assign pop_rd      = pop_data_i && data_available_o;
    assign rd_ptr_next = rd_ptr_q + {{ADDR_WID{1'b0}}, pop_rd};

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            wr_ptr_q     <= '0;
            wr_commit_q  <= '0;
            rd_ptr_q     <= '0;
            rd_release_q <= '0;
            overflow_q   <= 1'b0;
        end else begin
            if (fill_trans_done_i) begin
                overflow_q <= 1'b0;
                if (commit_ok) begin
                    wr_ptr_q    <= wr_ptr_next;
                    wr_commit_q <= wr_ptr_next; // Publish the packet.
                end else begin
                    wr_ptr_q <= wr_commit_q;    // Drop the partial packet.
                end
            end else begin
                wr_ptr_q   <= wr_ptr_next;
                overflow_q <= overflow_o;   // Sticky until the fill ends.
            end

            if (pop_trans_done_i) begin
                if (pop_trans_success_i) begin
                    rd_ptr_q     <= rd_ptr_next;
                    rd_release_q <= rd_ptr_next;
                end else begin
                    rd_ptr_q <= rd_release_q; // Rewind for a retry.
                end
            end else begin
                rd_ptr_q <= rd_ptr_next;
            end
        end
    end

    // A byte written together with the commit carries its own mark.
    always_ff @(posedge clk12_i) begin
        if (fill_wr) begin
            mem[wr_ptr_q[ADDR_WID-1:0]] <= {commit_ok, fill_data_i};
        end else if (commit_ok && (wr_ptr_q != wr_commit_q)) begin
            mem[last_ptr[ADDR_WID-1:0]][8] <= 1'b1;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (pop_rd) begin
            {is_last_byte_o, data_o} <= mem[rd_ptr_q[ADDR_WID-1:0]]; // One cycle behind.
        end
    end

endmodule
